//--- top_mips_stimulus.txt
// Word 0 is the program length, then the program words,
// then expected registers 1 to 15, then the expected final PC
00000016 // 22 program words
20010005 // addi $1, $0, 5
2002FFFD // addi $2, $0, -3
00221820 // add  $3, $1, $2
00222022 // sub  $4, $1, $2
00822824 // and  $5, $4, $2
00233025 // or   $6, $1, $3
0041382A // slt  $7, $2, $1
0022402A // slt  $8, $1, $2
2009FF9C // addi $9, $0, -100
AC090008 // sw   $9, 8($0)
8C0A0008 // lw   $10, 8($0)
01415820 // add  $11, $10, $1
216CFFFB // addi $12, $11, -5
01896822 // sub  $13, $12, $9
AC06000C // sw   $6, 12($0)
8C0E000C // lw   $14, 12($0)
01CB7822 // sub  $15, $14, $11
FC000000 // halt
00000000 // nop
00000000 // nop
00000000 // nop
00000000 // nop
00000005 // $1
FFFFFFFD // $2
00000002 // $3
00000008 // $4
00000008 // $5
00000007 // $6
00000001 // $7
00000000 // $8
FFFFFF9C // $9
FFFFFF9C // $10
FFFFFFA1 // $11
FFFFFF9C // $12
00000000 // $13
00000007 // $14
00000066 // $15
00000058 // final pc, halt address plus 20

//--- top_mips.f
mips_pkg.sv
instr_fetch.sv
register_file.sv
control_unit.sv
hazard_unit.sv
instr_decode.sv
execute.sv
mem_access.sv
top_mips.sv
tb_top_mips.sv

//--- tb_top_mips.sv
`timescale 1ns/1ps

module tb_top_mips;

    localparam int SIZE_MEM_INSTRUC   = 256;
    localparam int SIZE_MEM_DATA      = 64;
    localparam int SIZE_INSTRUC_DEBUG = 8;
    localparam int STIM_WORDS         = 128;
    localparam int NUM_REGS_CHECKED   = 15;
    localparam int HALT_TIMEOUT       = 4000;
    localparam int FREEZE_CYCLES      = 8;
    localparam int HOLD_CYCLES        = 20;

    logic                           i_clk;
    logic                           i_reset;
    logic                           i_step;
    logic [SIZE_INSTRUC_DEBUG-1:0]  i_select_address_mem_instr;
    logic [mips_pkg::BITS_REGS-1:0] i_select_address_register;
    logic [mips_pkg::BITS_SIZE-1:0] i_dato_mem_ins;
    logic                           i_flag_write_mem_ins;
    logic [mips_pkg::BITS_SIZE-1:0] o_pc;
    logic [mips_pkg::BITS_SIZE-1:0] o_data_reg_file;
    logic                           o_halt;

    logic [mips_pkg::BITS_SIZE-1:0] stim [STIM_WORDS];
    logic [31:0]                    lcg_state;
    logic                           run_enable;
    int                             value_errors;
    int                             other_errors;
    int                             prog_len;

    top_mips #(
        .SIZE_MEM_INSTRUC   (SIZE_MEM_INSTRUC),
        .SIZE_MEM_DATA      (SIZE_MEM_DATA),
        .SIZE_INSTRUC_DEBUG (SIZE_INSTRUC_DEBUG)
    ) top_mips_inst (
        .i_clk                      (i_clk),
        .i_reset                    (i_reset),
        .i_step                     (i_step),
        .i_select_address_mem_instr (i_select_address_mem_instr),
        .i_select_address_register  (i_select_address_register),
        .i_dato_mem_ins             (i_dato_mem_ins),
        .i_flag_write_mem_ins       (i_flag_write_mem_ins),
        .o_pc                       (o_pc),
        .o_data_reg_file            (o_data_reg_file),
        .o_halt                     (o_halt)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_word(input logic [mips_pkg::BITS_SIZE-1:0] got,
                              input logic [mips_pkg::BITS_SIZE-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // Length sane and every used word known
    function automatic bit stimulus_usable();
        int last;
        if ($isunknown(stim[0])) begin
            return 1'b0;
        end
        last = int'(stim[0]) + NUM_REGS_CHECKED + 1;
        if (stim[0] == '0 || last >= STIM_WORDS || stim[0] > 2**SIZE_INSTRUC_DEBUG) begin
            return 1'b0;
        end
        for (int i = 1; i <= last; i++) begin
            if ($isunknown(stim[i])) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge i_clk);
            i_flag_write_mem_ins       <= 1'b1;
            i_select_address_mem_instr <= SIZE_INSTRUC_DEBUG'(i);
            i_dato_mem_ins             <= stim[1 + i];
        end
        @(posedge i_clk);
        i_flag_write_mem_ins <= 1'b0;
    endtask

    task automatic read_register(input int index, input logic [mips_pkg::BITS_SIZE-1:0] exp,
                                 input string when);
        @(posedge i_clk);
        i_select_address_register <= mips_pkg::BITS_REGS'(index);
        @(negedge i_clk);
        check_word(o_data_reg_file, exp, $sformatf("reg %0d %s", index, when));
    endtask

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // Step strobe, high about three cycles in four
    initial begin
        i_step    = 1'b0;
        lcg_state = 32'h3412040f;
        forever begin
            @(posedge i_clk);
            if (run_enable) begin
                lcg_state = lcg_next(lcg_state);
                i_step <= (lcg_state[31:30] != 2'b00);
            end else begin
                i_step <= 1'b0;
            end
        end
    end

    initial begin
        logic [mips_pkg::BITS_SIZE-1:0] pc_before;
        int                             cycles;
        i_reset                    = 1'b1;
        i_select_address_mem_instr = '0;
        i_select_address_register  = '0;
        i_dato_mem_ins             = '0;
        i_flag_write_mem_ins       = 1'b0;
        run_enable                 = 1'b0;
        value_errors               = 0;
        other_errors               = 0;
        $readmemh("top_mips_stimulus.txt", stim);

        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        check_word(o_pc, '0, "pc after reset");
        check_flag(o_halt, 1'b0, "halt after reset");
        for (int r = 0; r < 2**mips_pkg::BITS_REGS; r++) begin
            read_register(r, '0, "after reset");
        end

        if (!stimulus_usable()) begin
            $display("Stimulus file is missing, malformed or has unknown words");
            other_errors++;
        end else begin
            prog_len = int'(stim[0]);
            load_program();

            // Pipeline must stay frozen without the step strobe
            @(negedge i_clk);
            pc_before = o_pc;
            repeat (FREEZE_CYCLES) begin
                @(negedge i_clk);
                check_word(o_pc, pc_before, "pc while step low");
            end

            @(posedge i_clk);
            run_enable <= 1'b1;
            cycles = 0;
            while (o_halt !== 1'b1 && cycles < HALT_TIMEOUT) begin
                @(negedge i_clk);
                cycles++;
            end

            if (o_halt === 1'b1) begin
                check_word(o_pc, stim[prog_len + NUM_REGS_CHECKED + 1], "final pc");
                repeat (HOLD_CYCLES) begin
                    @(negedge i_clk);
                    check_word(o_pc, stim[prog_len + NUM_REGS_CHECKED + 1], "pc after halt");
                    check_flag(o_halt, 1'b1, "halt held");
                end
                @(posedge i_clk);
                run_enable <= 1'b0;
                for (int r = 1; r <= NUM_REGS_CHECKED; r++) begin
                    read_register(r, stim[prog_len + r], "after halt");
                end
            end else begin
                $display("Timeout: o_halt did not rise within %0d cycles", HALT_TIMEOUT);
                other_errors++;
            end
        end

        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- top_mips.sv
`timescale 1ns/1ps

module top_mips #(
    parameter int SIZE_MEM_INSTRUC   = 256,
    parameter int SIZE_MEM_DATA      = 64,
    parameter int SIZE_INSTRUC_DEBUG = 8
) (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_step,
    input  logic [SIZE_INSTRUC_DEBUG-1:0]  i_select_address_mem_instr,
    input  logic [mips_pkg::BITS_REGS-1:0] i_select_address_register,
    input  logic [mips_pkg::BITS_SIZE-1:0] i_dato_mem_ins,
    input  logic                           i_flag_write_mem_ins,
    output logic [mips_pkg::BITS_SIZE-1:0] o_pc,
    output logic [mips_pkg::BITS_SIZE-1:0] o_data_reg_file,
    output logic                           o_halt
);

    logic [mips_pkg::BITS_SIZE-1:0] ifid_instr;
    logic [mips_pkg::BITS_REGS-1:0] ifid_rs;
    logic [mips_pkg::BITS_REGS-1:0] ifid_rt;
    logic                           uses_rt;
    logic                           stall;
    logic [mips_pkg::BITS_SIZE-1:0] idex_rs_data;
    logic [mips_pkg::BITS_SIZE-1:0] idex_rt_data;
    logic [mips_pkg::BITS_SIZE-1:0] idex_imm;
    logic [mips_pkg::BITS_REGS-1:0] idex_rd;
    logic                           idex_reg_write;
    logic                           idex_mem_read;
    logic                           idex_mem_write;
    logic                           idex_alu_src;
    logic                           idex_halt;
    mips_pkg::alu_op_t              idex_alu_op;
    logic [mips_pkg::BITS_SIZE-1:0] exmem_result;
    logic [mips_pkg::BITS_SIZE-1:0] exmem_store;
    logic [mips_pkg::BITS_REGS-1:0] exmem_rd;
    logic                           exmem_reg_write;
    logic                           exmem_mem_read;
    logic                           exmem_mem_write;
    logic                           exmem_halt;
    logic                           wb_write;
    logic [mips_pkg::BITS_REGS-1:0] wb_addr;
    logic [mips_pkg::BITS_SIZE-1:0] wb_data;

    instr_fetch #(
        .SIZE_MEM_INSTRUC   (SIZE_MEM_INSTRUC),
        .SIZE_INSTRUC_DEBUG (SIZE_INSTRUC_DEBUG)
    ) instr_fetch_inst (
        .i_clk                      (i_clk),
        .i_reset                    (i_reset),
        .i_step                     (i_step),
        .i_stall                    (stall),
        .i_halt                     (o_halt),
        .i_select_address_mem_instr (i_select_address_mem_instr),
        .i_dato_mem_ins             (i_dato_mem_ins),
        .i_flag_write_mem_ins       (i_flag_write_mem_ins),
        .o_pc                       (o_pc),
        .o_ifid_instr               (ifid_instr)
    );

    instr_decode instr_decode_inst (
        .i_clk                     (i_clk),
        .i_reset                   (i_reset),
        .i_step                    (i_step),
        .i_halt                    (o_halt),
        .i_stall                   (stall),
        .i_ifid_instr              (ifid_instr),
        .i_wb_write                (wb_write),
        .i_wb_addr                 (wb_addr),
        .i_wb_data                 (wb_data),
        .i_select_address_register (i_select_address_register),
        .o_data_reg_file           (o_data_reg_file),
        .o_ifid_rs                 (ifid_rs),
        .o_ifid_rt                 (ifid_rt),
        .o_uses_rt                 (uses_rt),
        .o_idex_rs_data            (idex_rs_data),
        .o_idex_rt_data            (idex_rt_data),
        .o_idex_imm                (idex_imm),
        .o_idex_rd                 (idex_rd),
        .o_idex_reg_write          (idex_reg_write),
        .o_idex_mem_read           (idex_mem_read),
        .o_idex_mem_write          (idex_mem_write),
        .o_idex_alu_src            (idex_alu_src),
        .o_idex_halt               (idex_halt),
        .o_idex_alu_op             (idex_alu_op)
    );

    hazard_unit hazard_unit_inst (
        .i_ifid_rs     (ifid_rs),
        .i_ifid_rt     (ifid_rt),
        .i_uses_rt     (uses_rt),
        .i_idex_rd     (idex_rd),
        .i_exmem_rd    (exmem_rd),
        .i_memwb_rd    (wb_addr),
        .i_idex_write  (idex_reg_write),
        .i_exmem_write (exmem_reg_write),
        .i_memwb_write (wb_write),
        .o_stall       (stall)
    );

    execute execute_inst (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_step            (i_step),
        .i_halt            (o_halt),
        .i_idex_rs_data    (idex_rs_data),
        .i_idex_rt_data    (idex_rt_data),
        .i_idex_imm        (idex_imm),
        .i_idex_rd         (idex_rd),
        .i_idex_reg_write  (idex_reg_write),
        .i_idex_mem_read   (idex_mem_read),
        .i_idex_mem_write  (idex_mem_write),
        .i_idex_alu_src    (idex_alu_src),
        .i_idex_halt       (idex_halt),
        .i_idex_alu_op     (idex_alu_op),
        .o_exmem_result    (exmem_result),
        .o_exmem_store     (exmem_store),
        .o_exmem_rd        (exmem_rd),
        .o_exmem_reg_write (exmem_reg_write),
        .o_exmem_mem_read  (exmem_mem_read),
        .o_exmem_mem_write (exmem_mem_write),
        .o_exmem_halt      (exmem_halt)
    );

    // Halt from write-back freezes every stage
    mem_access #(
        .SIZE_MEM_DATA (SIZE_MEM_DATA)
    ) mem_access_inst (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_step            (i_step),
        .i_halt            (o_halt),
        .i_exmem_result    (exmem_result),
        .i_exmem_store     (exmem_store),
        .i_exmem_rd        (exmem_rd),
        .i_exmem_reg_write (exmem_reg_write),
        .i_exmem_mem_read  (exmem_mem_read),
        .i_exmem_mem_write (exmem_mem_write),
        .i_exmem_halt      (exmem_halt),
        .o_wb_write        (wb_write),
        .o_wb_addr         (wb_addr),
        .o_wb_data         (wb_data),
        .o_wb_halt         (o_halt)
    );

endmodule

//--- mem_access.sv
`timescale 1ns/1ps

module mem_access #(
    parameter int SIZE_MEM_DATA = 64
) (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_step,
    input  logic                           i_halt,
    input  logic [mips_pkg::BITS_SIZE-1:0] i_exmem_result,
    input  logic [mips_pkg::BITS_SIZE-1:0] i_exmem_store,
    input  logic [mips_pkg::BITS_REGS-1:0] i_exmem_rd,
    input  logic                           i_exmem_reg_write,
    input  logic                           i_exmem_mem_read,
    input  logic                           i_exmem_mem_write,
    input  logic                           i_exmem_halt,
    output logic                           o_wb_write,
    output logic [mips_pkg::BITS_REGS-1:0] o_wb_addr,
    output logic [mips_pkg::BITS_SIZE-1:0] o_wb_data,
    output logic                           o_wb_halt
);

    localparam int DADDR_W = $clog2(SIZE_MEM_DATA);

    logic [mips_pkg::BITS_SIZE-1:0] dmem [SIZE_MEM_DATA];
    logic [DADDR_W-1:0]             word_idx;
    logic                           memwb_halt;
    logic                           advance;

    assign advance  = i_step && !i_halt;
    assign word_idx = i_exmem_result[DADDR_W+1:2];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < SIZE_MEM_DATA; i++) begin
                dmem[i] <= '0;
            end
        end else if (advance && i_exmem_mem_write) begin
            dmem[word_idx] <= i_exmem_store;
        end
    end

    // MEM/WB latch with a halt flag that stays set once it leaves the pipe
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_write <= 1'b0;
            memwb_halt <= 1'b0;
            o_wb_halt  <= 1'b0;
        end else if (advance) begin
            o_wb_write <= i_exmem_reg_write;
            memwb_halt <= i_exmem_halt;
            o_wb_halt  <= memwb_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (advance) begin
            o_wb_addr <= i_exmem_rd;
            o_wb_data <= i_exmem_mem_read ? dmem[word_idx] : i_exmem_result;
        end
    end

    assert property (@(posedge i_clk) disable iff (i_reset)
        (i_exmem_mem_read || i_exmem_mem_write) |-> (i_exmem_result[1:0] == 2'b00));

endmodule

//--- execute.sv
`timescale 1ns/1ps

module execute (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_step,
    input  logic                           i_halt,
    input  logic [mips_pkg::BITS_SIZE-1:0] i_idex_rs_data,
    input  logic [mips_pkg::BITS_SIZE-1:0] i_idex_rt_data,
    input  logic [mips_pkg::BITS_SIZE-1:0] i_idex_imm,
    input  logic [mips_pkg::BITS_REGS-1:0] i_idex_rd,
    input  logic                           i_idex_reg_write,
    input  logic                           i_idex_mem_read,
    input  logic                           i_idex_mem_write,
    input  logic                           i_idex_alu_src,
    input  logic                           i_idex_halt,
    input  mips_pkg::alu_op_t              i_idex_alu_op,
    output logic [mips_pkg::BITS_SIZE-1:0] o_exmem_result,
    output logic [mips_pkg::BITS_SIZE-1:0] o_exmem_store,
    output logic [mips_pkg::BITS_REGS-1:0] o_exmem_rd,
    output logic                           o_exmem_reg_write,
    output logic                           o_exmem_mem_read,
    output logic                           o_exmem_mem_write,
    output logic                           o_exmem_halt
);

    logic [mips_pkg::BITS_SIZE-1:0] operand_b;
    logic [mips_pkg::BITS_SIZE-1:0] alu_result;
    logic                           advance;

    assign advance   = i_step && !i_halt;
    assign operand_b = i_idex_alu_src ? i_idex_imm : i_idex_rt_data;

    always_comb begin
        case (i_idex_alu_op)
            mips_pkg::ALU_SUB: alu_result = i_idex_rs_data - operand_b;
            mips_pkg::ALU_AND: alu_result = i_idex_rs_data & operand_b;
            mips_pkg::ALU_OR:  alu_result = i_idex_rs_data | operand_b;
            // Signed compare
            mips_pkg::ALU_SLT: alu_result = {{(mips_pkg::BITS_SIZE-1){1'b0}},
                                             $signed(i_idex_rs_data) < $signed(operand_b)};
            default:           alu_result = i_idex_rs_data + operand_b;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_exmem_reg_write <= 1'b0;
            o_exmem_mem_read  <= 1'b0;
            o_exmem_mem_write <= 1'b0;
            o_exmem_halt      <= 1'b0;
        end else if (advance) begin
            o_exmem_reg_write <= i_idex_reg_write;
            o_exmem_mem_read  <= i_idex_mem_read;
            o_exmem_mem_write <= i_idex_mem_write;
            o_exmem_halt      <= i_idex_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (advance) begin
            o_exmem_result <= alu_result;
            o_exmem_store  <= i_idex_rt_data;
            o_exmem_rd     <= i_idex_rd;
        end
    end

endmodule

//--- instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_step,
    input  logic                           i_halt,
    input  logic                           i_stall,
    input  logic [mips_pkg::BITS_SIZE-1:0] i_ifid_instr,
    input  logic                           i_wb_write,
    input  logic [mips_pkg::BITS_REGS-1:0] i_wb_addr,
    input  logic [mips_pkg::BITS_SIZE-1:0] i_wb_data,
    input  logic [mips_pkg::BITS_REGS-1:0] i_select_address_register,
    output logic [mips_pkg::BITS_SIZE-1:0] o_data_reg_file,
    output logic [mips_pkg::BITS_REGS-1:0] o_ifid_rs,
    output logic [mips_pkg::BITS_REGS-1:0] o_ifid_rt,
    output logic                           o_uses_rt,
    output logic [mips_pkg::BITS_SIZE-1:0] o_idex_rs_data,
    output logic [mips_pkg::BITS_SIZE-1:0] o_idex_rt_data,
    output logic [mips_pkg::BITS_SIZE-1:0] o_idex_imm,
    output logic [mips_pkg::BITS_REGS-1:0] o_idex_rd,
    output logic                           o_idex_reg_write,
    output logic                           o_idex_mem_read,
    output logic                           o_idex_mem_write,
    output logic                           o_idex_alu_src,
    output logic                           o_idex_halt,
    output mips_pkg::alu_op_t              o_idex_alu_op
);

    logic [mips_pkg::BITS_INMEDIATE-1:0] imm16;
    logic [mips_pkg::BITS_REGS-1:0]      rd_field;
    logic [mips_pkg::BITS_SIZE-1:0]      rs_data;
    logic [mips_pkg::BITS_SIZE-1:0]      rt_data;
    mips_pkg::opcode_t                   opcode;
    mips_pkg::funct_t                    funct;
    mips_pkg::alu_op_t                   ctl_alu_op;
    logic ctl_reg_write;
    logic ctl_reg_dst_rd;
    logic ctl_alu_src;
    logic ctl_mem_read;
    logic ctl_mem_write;
    logic ctl_halt;
    logic advance;

    assign opcode    = mips_pkg::opcode_t'(i_ifid_instr[mips_pkg::OPCODE_LSB +:
                                                        mips_pkg::BITS_SIZE_CTL]);
    assign funct     = mips_pkg::funct_t'(i_ifid_instr[mips_pkg::BITS_SIZE_CTL-1:0]);
    assign o_ifid_rs = i_ifid_instr[mips_pkg::RS_LSB +: mips_pkg::BITS_REGS];
    assign o_ifid_rt = i_ifid_instr[mips_pkg::RT_LSB +: mips_pkg::BITS_REGS];
    assign rd_field  = i_ifid_instr[mips_pkg::RD_LSB +: mips_pkg::BITS_REGS];
    assign imm16     = i_ifid_instr[mips_pkg::BITS_INMEDIATE-1:0];
    assign advance   = i_step && !i_halt;

    register_file register_file_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_step       (i_step),
        .i_halt       (i_halt),
        .i_write      (i_wb_write),
        .i_addr_rs    (o_ifid_rs),
        .i_addr_rt    (o_ifid_rt),
        .i_addr_wr    (i_wb_addr),
        .i_addr_debug (i_select_address_register),
        .i_data_wr    (i_wb_data),
        .o_rs         (rs_data),
        .o_rt         (rt_data),
        .o_data_debug (o_data_reg_file)
    );

    control_unit control_unit_inst (
        .i_opcode     (opcode),
        .i_funct      (funct),
        .o_reg_write  (ctl_reg_write),
        .o_reg_dst_rd (ctl_reg_dst_rd),
        .o_alu_src    (ctl_alu_src),
        .o_mem_read   (ctl_mem_read),
        .o_mem_write  (ctl_mem_write),
        .o_halt       (ctl_halt),
        .o_uses_rt    (o_uses_rt),
        .o_alu_op     (ctl_alu_op)
    );

    // ID/EX controls get a bubble on a stall
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_idex_reg_write <= 1'b0;
            o_idex_mem_read  <= 1'b0;
            o_idex_mem_write <= 1'b0;
            o_idex_halt      <= 1'b0;
        end else if (advance) begin
            o_idex_reg_write <= ctl_reg_write && !i_stall;
            o_idex_mem_read  <= ctl_mem_read && !i_stall;
            o_idex_mem_write <= ctl_mem_write && !i_stall;
            o_idex_halt      <= ctl_halt && !i_stall;
        end
    end

    always_ff @(posedge i_clk) begin
        if (advance) begin
            o_idex_rs_data <= rs_data;
            o_idex_rt_data <= rt_data;
            o_idex_imm     <= {{(mips_pkg::BITS_SIZE-mips_pkg::BITS_INMEDIATE){imm16[
                               mips_pkg::BITS_INMEDIATE-1]}}, imm16};
            o_idex_rd      <= ctl_reg_dst_rd ? rd_field : o_ifid_rt;
            o_idex_alu_src <= ctl_alu_src;
            o_idex_alu_op  <= ctl_alu_op;
        end
    end

    // A source still being written back keeps the instruction in decode
    assert property (@(posedge i_clk) disable iff (i_reset)
        (advance && i_wb_write && (i_wb_addr != '0) &&
         ((i_wb_addr == o_ifid_rs) || (o_uses_rt && (i_wb_addr == o_ifid_rt))))
        |-> i_stall);

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic [mips_pkg::BITS_REGS-1:0] i_ifid_rs,
    input  logic [mips_pkg::BITS_REGS-1:0] i_ifid_rt,
    input  logic                           i_uses_rt,
    input  logic [mips_pkg::BITS_REGS-1:0] i_idex_rd,
    input  logic [mips_pkg::BITS_REGS-1:0] i_exmem_rd,
    input  logic [mips_pkg::BITS_REGS-1:0] i_memwb_rd,
    input  logic                           i_idex_write,
    input  logic                           i_exmem_write,
    input  logic                           i_memwb_write,
    output logic                           o_stall
);

    logic rs_busy;
    logic rt_busy;

    // Source still pending in one of the three older stages
    function automatic logic pending(input logic [mips_pkg::BITS_REGS-1:0] src);
        return (i_idex_write  && (i_idex_rd  != '0) && (i_idex_rd  == src)) ||
               (i_exmem_write && (i_exmem_rd != '0) && (i_exmem_rd == src)) ||
               (i_memwb_write && (i_memwb_rd != '0) && (i_memwb_rd == src));
    endfunction

    assign rs_busy = pending(i_ifid_rs);
    assign rt_busy = pending(i_ifid_rt);
    assign o_stall = rs_busy || (i_uses_rt && rt_busy);

endmodule

//--- control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  mips_pkg::opcode_t i_opcode,
    input  mips_pkg::funct_t  i_funct,
    output logic              o_reg_write,
    output logic              o_reg_dst_rd,
    output logic              o_alu_src,
    output logic              o_mem_read,
    output logic              o_mem_write,
    output logic              o_halt,
    output logic              o_uses_rt,
    output mips_pkg::alu_op_t o_alu_op
);

    always_comb begin
        o_reg_write  = 1'b0;
        o_reg_dst_rd = 1'b0;
        o_alu_src    = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_halt       = 1'b0;
        o_uses_rt    = 1'b0;
        o_alu_op     = mips_pkg::ALU_ADD;
        case (i_opcode)
            mips_pkg::OP_RTYPE: begin
                o_reg_write  = 1'b1;
                o_reg_dst_rd = 1'b1;
                o_uses_rt    = 1'b1;
                case (i_funct)
                    mips_pkg::FN_ADD: o_alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: o_alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: o_alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  o_alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: o_alu_op = mips_pkg::ALU_SLT;
                    default: begin
                        // nop and unknown funct become a bubble
                        o_reg_write  = 1'b0;
                        o_reg_dst_rd = 1'b0;
                        o_uses_rt    = 1'b0;
                    end
                endcase
            end
            mips_pkg::OP_ADDI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
            end
            mips_pkg::OP_LW: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_mem_read  = 1'b1;
            end
            mips_pkg::OP_SW: begin
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
                o_uses_rt   = 1'b1;
            end
            mips_pkg::OP_HALT: o_halt = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_step,
    input  logic                           i_halt,
    input  logic                           i_write,
    input  logic [mips_pkg::BITS_REGS-1:0] i_addr_rs,
    input  logic [mips_pkg::BITS_REGS-1:0] i_addr_rt,
    input  logic [mips_pkg::BITS_REGS-1:0] i_addr_wr,
    input  logic [mips_pkg::BITS_REGS-1:0] i_addr_debug,
    input  logic [mips_pkg::BITS_SIZE-1:0] i_data_wr,
    output logic [mips_pkg::BITS_SIZE-1:0] o_rs,
    output logic [mips_pkg::BITS_SIZE-1:0] o_rt,
    output logic [mips_pkg::BITS_SIZE-1:0] o_data_debug
);

    logic [mips_pkg::BITS_SIZE-1:0] regs [2**mips_pkg::BITS_REGS];

    assign o_rs         = regs[i_addr_rs];
    assign o_rt         = regs[i_addr_rt];
    assign o_data_debug = regs[i_addr_debug];

    // Register 0 is never written so it keeps its reset value of zero
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 2**mips_pkg::BITS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_step && !i_halt && i_write && (i_addr_wr != '0)) begin
            regs[i_addr_wr] <= i_data_wr;
        end
    end

endmodule

//--- instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch #(
    parameter int SIZE_MEM_INSTRUC   = 256,
    parameter int SIZE_INSTRUC_DEBUG = 8
) (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_step,
    input  logic                              i_stall,
    input  logic                              i_halt,
    input  logic [SIZE_INSTRUC_DEBUG-1:0]     i_select_address_mem_instr,
    input  logic [mips_pkg::BITS_SIZE-1:0]    i_dato_mem_ins,
    input  logic                              i_flag_write_mem_ins,
    output logic [mips_pkg::BITS_SIZE-1:0]    o_pc,
    output logic [mips_pkg::BITS_SIZE-1:0]    o_ifid_instr
);

    localparam int IDX_W = $clog2(SIZE_MEM_INSTRUC);

    logic [mips_pkg::BITS_SIZE-1:0] imem [SIZE_MEM_INSTRUC];
    logic [mips_pkg::BITS_SIZE-1:0] fetch_instr;
    logic                           advance;

    assign advance     = i_step && !i_halt && !i_stall;
    assign fetch_instr = imem[o_pc[IDX_W+1:2]];

    // Program load works regardless of the step strobe
    always_ff @(posedge i_clk) begin
        if (i_flag_write_mem_ins) begin
            imem[i_select_address_mem_instr] <= i_dato_mem_ins;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pc         <= '0;
            o_ifid_instr <= '0;
        end else if (advance) begin
            o_pc         <= o_pc + mips_pkg::BITS_SIZE'(4);
            o_ifid_instr <= fetch_instr;
        end
    end

    // PC must stay inside the instruction memory
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_pc[mips_pkg::BITS_SIZE-1:2] < SIZE_MEM_INSTRUC);

endmodule

//--- mips_pkg.sv
package mips_pkg;

    // Datapath and instruction widths
    localparam int BITS_SIZE      = 32;
    localparam int BITS_REGS      = 5;
    localparam int BITS_INMEDIATE = 16;
    localparam int BITS_SIZE_CTL  = 6;

    // Field positions inside an instruction word
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;

    typedef enum logic [BITS_SIZE_CTL-1:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd8,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43,
        OP_HALT  = 6'd63
    } opcode_t;

    // R-type function field
    typedef enum logic [BITS_SIZE_CTL-1:0] {
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_SLT = 6'd42
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

endpackage
